// File: hw/clbp_pkg.sv
`default_nettype none

package clbp_pkg;

  // riu2 coding for an eight-neighbor ring
  localparam int NEIGHBORS = 8;

  // S and M take 0..8 for uniform rings, 9 for everything else
  localparam int CODE_LEVELS = 10;

  // C (2) x S (10) x M (10)
  localparam int NUM_BINS = 200;

  localparam int PIX_W_DEFAULT = 8;
  localparam int COUNT_W_DEFAULT = 16;

  typedef logic [3:0] code_t;
  typedef logic [7:0] bin_idx_t;

endpackage

`default_nettype wire

// File: hw/jh_ctrl_pkg.sv
`default_nettype none

package jh_ctrl_pkg;

  // histogram controller states
  typedef enum logic {
    // accepting coded samples
    ST_COUNT = 1'b0,
    // streaming all bins out
    ST_READ  = 1'b1
  } jh_state_e;

endpackage

`default_nettype wire

// File: hw/clbp_code_if.sv
`timescale 1ns/10ps
`default_nettype none

interface clbp_code_if;
  import clbp_pkg::*;

  // one-cycle strobe, c/s/m only meaningful while high
  logic  valid;
  logic  c;
  code_t s;
  code_t m;

  modport enc (
    output valid,
    output c,
    output s,
    output m
  );

  modport hist (
    input valid,
    input c,
    input s,
    input m
  );

endinterface

`default_nettype wire

// File: hw/clbp_encoder.sv
`timescale 1ns/10ps
`default_nettype none

module clbp_encoder #(
  parameter int PIX_W = clbp_pkg::PIX_W_DEFAULT
) (
  input  wire                                  clk,
  input  wire                                  rst_n,
  input  wire                                  pixel_valid_i,
  input  wire [PIX_W-1:0]                      center_i,
  input  wire [clbp_pkg::NEIGHBORS*PIX_W-1:0]  neighbors_i,
  input  wire [PIX_W-1:0]                      c_thresh_i,
  input  wire [PIX_W-1:0]                      m_thresh_i,
  clbp_code_if.enc                             code_o
);
  import clbp_pkg::*;

  logic [PIX_W-1:0]     nbr  [NEIGHBORS];
  logic [PIX_W-1:0]     diff [NEIGHBORS];
  logic [NEIGHBORS-1:0] sign_ring;
  logic [NEIGHBORS-1:0] mag_ring;
  logic                 c_bit;
  code_t                s_code;
  code_t                m_code;

  // rotation-invariant uniform code of one bit ring
  function automatic code_t riu2_code(input logic [NEIGHBORS-1:0] ring);
    int transitions;
    int ones;
    transitions = 0;
    ones = 0;
    for (int k = 0; k < NEIGHBORS; k++) begin
      // circular, so the last bit is compared with bit 0
      transitions += int'(ring[k] ^ ring[(k + 1) % NEIGHBORS]);
      ones += int'(ring[k]);
    end
    if (transitions <= 2) begin
      riu2_code = code_t'(ones);
    end else begin
      riu2_code = code_t'(CODE_LEVELS - 1);
    end
  endfunction

  // sign and magnitude rings
  always_comb begin
    for (int k = 0; k < NEIGHBORS; k++) begin
      nbr[k] = neighbors_i[k*PIX_W +: PIX_W];
      if (nbr[k] >= center_i) begin
        diff[k] = nbr[k] - center_i;
      end else begin
        diff[k] = center_i - nbr[k];
      end
      sign_ring[k] = (nbr[k] >= center_i);
      mag_ring[k]  = (diff[k] >= m_thresh_i);
    end
  end

  assign c_bit  = (center_i >= c_thresh_i);
  assign s_code = riu2_code(sign_ring);
  assign m_code = riu2_code(mag_ring);

  // single output stage
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      code_o.valid <= 1'b0;
    end else begin
      code_o.valid <= pixel_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (pixel_valid_i) begin
      code_o.c <= c_bit;
      code_o.s <= s_code;
      code_o.m <= m_code;
    end
  end

endmodule

`default_nettype wire

// File: hw/joint_hist_datapath.sv
`timescale 1ns/10ps
`default_nettype none

module joint_hist_datapath #(
  parameter int COUNT_W = clbp_pkg::COUNT_W_DEFAULT
) (
  input  wire                clk,
  input  wire                rst_n,
  clbp_code_if.hist          code_i,
  input  wire                count_en,
  input  wire                read_en,
  input  wire                clear_en,
  output logic [COUNT_W-1:0] bin_o,
  output logic               bin_valid_o,
  output logic               bin_last_o
);
  import clbp_pkg::*;

  // bin = c*100 + s*10 + m
  localparam bin_idx_t C_WEIGHT = bin_idx_t'(CODE_LEVELS * CODE_LEVELS);
  localparam bin_idx_t S_WEIGHT = bin_idx_t'(CODE_LEVELS);
  localparam bin_idx_t LAST_BIN = bin_idx_t'(NUM_BINS - 1);

  logic [COUNT_W-1:0] counters [NUM_BINS];
  bin_idx_t           idx_d;
  bin_idx_t           idx_q;
  logic               idx_valid_q;
  logic               sample_take;
  bin_idx_t           rd_idx_q;

  assign sample_take = code_i.valid && count_en;

  assign idx_d = (code_i.c ? C_WEIGHT : '0)
               + S_WEIGHT * bin_idx_t'(code_i.s)
               + bin_idx_t'(code_i.m);

  // index stage
  always_ff @(posedge clk) begin
    if (!rst_n || clear_en) begin
      idx_valid_q <= 1'b0;
    end else begin
      idx_valid_q <= sample_take;
    end
  end

  always_ff @(posedge clk) begin
    if (sample_take) begin
      idx_q <= idx_d;
    end
  end

  // increment stage, bins wrap at full scale
  always_ff @(posedge clk) begin
    if (!rst_n || clear_en) begin
      for (int b = 0; b < NUM_BINS; b++) begin
        counters[b] <= '0;
      end
    end else if (idx_valid_q) begin
      counters[idx_q] <= counters[idx_q] + COUNT_W'(1);
    end
  end

  // readout, one bin per cycle while read_en is up
  // bin_last_o holds off the extra cycle before the controller drops read_en
  always_ff @(posedge clk) begin
    if (!rst_n || clear_en) begin
      rd_idx_q    <= '0;
      bin_o       <= '0;
      bin_valid_o <= 1'b0;
      bin_last_o  <= 1'b0;
    end else if (read_en && !bin_last_o) begin
      bin_o       <= counters[rd_idx_q];
      bin_valid_o <= 1'b1;
      bin_last_o  <= (rd_idx_q == LAST_BIN);
      if (rd_idx_q == LAST_BIN) begin
        rd_idx_q <= '0;
      end else begin
        rd_idx_q <= rd_idx_q + 1'b1;
      end
    end else begin
      bin_o       <= '0;
      bin_valid_o <= 1'b0;
      bin_last_o  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hw/jh_controller.sv
`timescale 1ns/10ps
`default_nettype none

module jh_controller (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  clear_i,
  input  wire  read_i,
  input  wire  bin_last_i,
  output logic count_en_o,
  output logic read_en_o,
  output logic clear_en_o,
  output logic busy_o
);
  import jh_ctrl_pkg::*;

  jh_state_e state_q;
  jh_state_e state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_COUNT: begin
        if (read_i) begin
          state_d = ST_READ;
        end
      end
      ST_READ: begin
        // read_i is ignored here
        if (bin_last_i) begin
          state_d = ST_COUNT;
        end
      end
      default: begin
        state_d = ST_COUNT;
      end
    endcase
    // clear aborts a readout and beats a same-cycle read
    if (clear_i) begin
      state_d = ST_COUNT;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= ST_COUNT;
    end else begin
      state_q <= state_d;
    end
  end

  assign count_en_o = (state_q == ST_COUNT);
  assign read_en_o  = (state_q == ST_READ);
  assign busy_o     = (state_q == ST_READ);

  // zeroing happens on the same edge as the state change
  assign clear_en_o = clear_i;

endmodule

`default_nettype wire

// File: hw/clbp_hist_top.sv
`timescale 1ns/10ps
`default_nettype none

module clbp_hist_top #(
  parameter int PIX_W   = clbp_pkg::PIX_W_DEFAULT,
  parameter int COUNT_W = clbp_pkg::COUNT_W_DEFAULT
) (
  input  wire                                 clk,
  input  wire                                 rst_n,
  input  wire                                 clear_i,
  input  wire                                 read_i,
  input  wire                                 pixel_valid_i,
  input  wire [PIX_W-1:0]                     center_i,
  input  wire [clbp_pkg::NEIGHBORS*PIX_W-1:0] neighbors_i,
  input  wire [PIX_W-1:0]                     c_thresh_i,
  input  wire [PIX_W-1:0]                     m_thresh_i,
  output wire [COUNT_W-1:0]                   bin_o,
  output wire                                 bin_valid_o,
  output wire                                 bin_last_o,
  output wire                                 busy_o
);

  wire count_en;
  wire read_en;
  wire clear_en;

  clbp_code_if code_bus ();

  clbp_encoder #(
    .PIX_W (PIX_W)
  ) u_encoder (
    .clk           (clk),
    .rst_n         (rst_n),
    .pixel_valid_i (pixel_valid_i),
    .center_i      (center_i),
    .neighbors_i   (neighbors_i),
    .c_thresh_i    (c_thresh_i),
    .m_thresh_i    (m_thresh_i),
    .code_o        (code_bus.enc)
  );

  // bin_last_o also ends the readout in the controller
  jh_controller u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .clear_i    (clear_i),
    .read_i     (read_i),
    .bin_last_i (bin_last_o),
    .count_en_o (count_en),
    .read_en_o  (read_en),
    .clear_en_o (clear_en),
    .busy_o     (busy_o)
  );

  joint_hist_datapath #(
    .COUNT_W (COUNT_W)
  ) u_datapath (
    .clk         (clk),
    .rst_n       (rst_n),
    .code_i      (code_bus.hist),
    .count_en    (count_en),
    .read_en     (read_en),
    .clear_en    (clear_en),
    .bin_o       (bin_o),
    .bin_valid_o (bin_valid_o),
    .bin_last_o  (bin_last_o)
  );

endmodule

`default_nettype wire

// File: tests/clbp_hist_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module clbp_hist_assertions #(
  parameter int COUNT_W = clbp_pkg::COUNT_W_DEFAULT
) (
  input wire               clk,
  input wire               rst_n,
  input wire [COUNT_W-1:0] bin_i,
  input wire               bin_valid_i,
  input wire               bin_last_i,
  input wire               busy_i
);
  import jh_ctrl_pkg::*;

  jh_state_e ctrl_mode;

  // busy_o mirrors the controller sitting in ST_READ
  assign ctrl_mode = busy_i ? ST_READ : ST_COUNT;

  last_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
    bin_last_i |-> bin_valid_i)
    else $error("bin_last_o high without bin_valid_o");

  idle_bin_zero: assert property (@(posedge clk) disable iff (!rst_n)
    !bin_valid_i |-> bin_i == '0)
    else $error("bin_o nonzero while bin_valid_o is low");

  valid_only_reading: assert property (@(posedge clk) disable iff (!rst_n)
    bin_valid_i |-> ctrl_mode == ST_READ)
    else $error("bin_valid_o high while busy_o is low");

endmodule

bind clbp_hist_top clbp_hist_assertions #(
  .COUNT_W (COUNT_W)
) u_assertions (
  .clk         (clk),
  .rst_n       (rst_n),
  .bin_i       (bin_o),
  .bin_valid_i (bin_valid_o),
  .bin_last_i  (bin_last_o),
  .busy_i      (busy_o)
);

`default_nettype wire

// File: tests/tb_clbp_hist.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clbp_hist;
  import clbp_pkg::*;

  localparam int PIX_W = 8;
  localparam int COUNT_W = 16;
  localparam int NUM_VEC = 30;
  localparam int VEC_BYTES = 12;
  localparam int NUM_RAND = 300;
  localparam int NUM_READOUTS = 6;
  localparam int READ_CYCLES = 204;
  localparam int CYCLE_LIMIT = NUM_VEC + NUM_RAND + NUM_READOUTS * READ_CYCLES + 200;

  logic                       clk;
  logic                       rst_n;
  logic                       clear_i;
  logic                       read_i;
  logic                       pixel_valid_i;
  logic [PIX_W-1:0]           center_i;
  logic [NEIGHBORS*PIX_W-1:0] neighbors_i;
  logic [PIX_W-1:0]           c_thresh_i;
  logic [PIX_W-1:0]           m_thresh_i;
  wire  [COUNT_W-1:0]         bin_o;
  wire                        bin_valid_o;
  wire                        bin_last_o;
  wire                        busy_o;

  // word 0 is the window count, then 12 bytes per window
  logic [7:0]         vec_mem [0:NUM_VEC*VEC_BYTES];
  int                 exp_count [NUM_BINS];
  logic [COUNT_W-1:0] read_bins [NUM_BINS];
  logic [31:0]        rng_state;
  int                 mismatch_errors;
  int                 other_errors;
  int                 cycle_count;

  clbp_hist_top #(
    .PIX_W   (PIX_W),
    .COUNT_W (COUNT_W)
  ) i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .clear_i       (clear_i),
    .read_i        (read_i),
    .pixel_valid_i (pixel_valid_i),
    .center_i      (center_i),
    .neighbors_i   (neighbors_i),
    .c_thresh_i    (c_thresh_i),
    .m_thresh_i    (m_thresh_i),
    .bin_o         (bin_o),
    .bin_valid_o   (bin_valid_o),
    .bin_last_o    (bin_last_o),
    .busy_o        (busy_o)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("timeout: readout never finished");
      $display("errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
      $display("Test failures found");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // uniform ring = at most one run of ones around the circle
  function automatic int ring_level(input logic [NEIGHBORS-1:0] ring);
    int runs;
    int ones;
    runs = 0;
    ones = 0;
    for (int k = 0; k < NEIGHBORS; k++) begin
      ones += int'(ring[k]);
      if (ring[k] && !ring[(k + NEIGHBORS - 1) % NEIGHBORS]) begin
        runs++;
      end
    end
    return (runs <= 1) ? ones : CODE_LEVELS - 1;
  endfunction

  task automatic expected_bin(input logic [PIX_W-1:0] c, input logic [NEIGHBORS*PIX_W-1:0] nbrs,
                              input logic [PIX_W-1:0] ct, input logic [PIX_W-1:0] mt,
                              output int bin);
    logic [NEIGHBORS-1:0] sign_ring;
    logic [NEIGHBORS-1:0] mag_ring;
    int                   d;
    for (int k = 0; k < NEIGHBORS; k++) begin
      d = int'(nbrs[k*PIX_W +: PIX_W]) - int'(c);
      sign_ring[k] = (d >= 0);
      mag_ring[k]  = (((d < 0) ? -d : d) >= int'(mt));
    end
    bin = ((c >= ct) ? CODE_LEVELS * CODE_LEVELS : 0)
        + CODE_LEVELS * ring_level(sign_ring) + ring_level(mag_ring);
  endtask

  task automatic apply_window(input logic [PIX_W-1:0] c, input logic [NEIGHBORS*PIX_W-1:0] nbrs,
                              input logic [PIX_W-1:0] ct, input logic [PIX_W-1:0] mt);
    pixel_valid_i = 1'b1;
    center_i      = c;
    neighbors_i   = nbrs;
    c_thresh_i    = ct;
    m_thresh_i    = mt;
  endtask

  task automatic random_window(output logic [PIX_W-1:0] c,
                               output logic [NEIGHBORS*PIX_W-1:0] nbrs,
                               output logic [PIX_W-1:0] ct, output logic [PIX_W-1:0] mt);
    rng_state = xorshift32(rng_state);
    c  = rng_state[7:0];
    ct = rng_state[15:8];
    // keep the magnitude threshold small so M stays varied
    mt = {2'b00, rng_state[21:16]};
    for (int k = 0; k < NEIGHBORS; k++) begin
      rng_state = xorshift32(rng_state);
      // within 16 of the centre, wrapping at the byte edge
      nbrs[k*PIX_W +: PIX_W] = c + {3'b000, rng_state[4:0]} - 8'd16;
    end
  endtask

  // mode 0 plain, 1 pixels and a read pulse during readout, 2 clear at bin 100
  task automatic read_histogram(input string name, input int mode);
    logic [PIX_W-1:0]           c;
    logic [NEIGHBORS*PIX_W-1:0] nbrs;
    logic [PIX_W-1:0]           ct;
    logic [PIX_W-1:0]           mt;
    @(negedge clk);
    read_i = 1'b1;
    @(negedge clk);
    read_i = 1'b0;
    assert (busy_o) else begin
      other_errors++;
      $display("%s: busy_o is low the cycle after read_i", name);
    end
    while (!bin_valid_o) begin
      @(negedge clk);
    end
    for (int b = 0; b < NUM_BINS; b++) begin
      assert (bin_valid_o && busy_o) else begin
        other_errors++;
        $display("%s: bin_valid_o or busy_o dropped at bin %0d", name, b);
      end
      assert (bin_last_o == (b == NUM_BINS - 1)) else begin
        other_errors++;
        $display("%s: bin_last_o has the wrong level at bin %0d", name, b);
      end
      read_bins[b] = bin_o;
      if (mode == 1 && b < 50) begin
        random_window(c, nbrs, ct, mt);
        apply_window(c, nbrs, ct, mt);
        read_i = (b == 20);
      end else begin
        pixel_valid_i = 1'b0;
        read_i = 1'b0;
      end
      if (mode == 2 && b == 100) begin
        clear_i = 1'b1;
        @(negedge clk);
        clear_i = 1'b0;
        assert (!bin_valid_o && !busy_o) else begin
          other_errors++;
          $display("%s: clear did not end the readout", name);
        end
        return;
      end
      @(negedge clk);
    end
    assert (!bin_valid_o && !bin_last_o && bin_o == '0 && !busy_o) else begin
      other_errors++;
      $display("%s: outputs not idle after the last bin", name);
    end
  endtask

  task automatic check_bins(input string name);
    for (int b = 0; b < NUM_BINS; b++) begin
      assert (read_bins[b] == COUNT_W'(exp_count[b])) else begin
        mismatch_errors++;
        $display("mismatch %s bin %0d: expected %0d, actual %0d",
                 name, b, exp_count[b], read_bins[b]);
      end
    end
  endtask

  initial begin
    logic [PIX_W-1:0]           c;
    logic [NEIGHBORS*PIX_W-1:0] nbrs;
    logic [PIX_W-1:0]           ct;
    logic [PIX_W-1:0]           mt;
    int                         base;
    int                         file_bin;
    int                         model_bin;
    rst_n = 1'b0;
    clear_i = 1'b0;
    read_i = 1'b0;
    pixel_valid_i = 1'b0;
    center_i = '0;
    neighbors_i = '0;
    c_thresh_i = '0;
    m_thresh_i = '0;
    mismatch_errors = 0;
    other_errors = 0;
    cycle_count = 0;
    rng_state = 32'h284a_9a11;
    for (int b = 0; b < NUM_BINS; b++) begin
      exp_count[b] = 0;
    end
    $readmemh("tests/clbp_vectors.hex", vec_mem);
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    assert (!busy_o && !bin_valid_o && !bin_last_o) else begin
      other_errors++;
      $display("reset: busy_o, bin_valid_o or bin_last_o high after reset");
    end
    read_histogram("reset", 0);
    check_bins("reset");

    // file windows back to back
    assert (vec_mem[0] == 8'(NUM_VEC)) else begin
      other_errors++;
      $display("vectors: file header gives %0d windows, not %0d", vec_mem[0], NUM_VEC);
    end
    for (int i = 0; i < NUM_VEC; i++) begin
      base = 1 + i * VEC_BYTES;
      c = vec_mem[base];
      for (int k = 0; k < NEIGHBORS; k++) begin
        nbrs[k*PIX_W +: PIX_W] = vec_mem[base + 1 + k];
      end
      ct = vec_mem[base + 9];
      mt = vec_mem[base + 10];
      file_bin = int'(vec_mem[base + 11]);
      expected_bin(c, nbrs, ct, mt, model_bin);
      assert (model_bin == file_bin) else begin
        other_errors++;
        $display("vectors: window %0d file bin %0d disagrees with riu2 rule bin %0d",
                 i, file_bin, model_bin);
      end
      exp_count[file_bin]++;
      @(negedge clk);
      apply_window(c, nbrs, ct, mt);
    end
    @(negedge clk);
    pixel_valid_i = 1'b0;
    repeat (3) @(negedge clk);
    read_histogram("vectors", 0);
    check_bins("vectors");

    // clear, then random windows
    @(negedge clk);
    clear_i = 1'b1;
    @(negedge clk);
    clear_i = 1'b0;
    for (int b = 0; b < NUM_BINS; b++) begin
      exp_count[b] = 0;
    end
    for (int i = 0; i < NUM_RAND; i++) begin
      random_window(c, nbrs, ct, mt);
      expected_bin(c, nbrs, ct, mt, model_bin);
      exp_count[model_bin]++;
      @(negedge clk);
      apply_window(c, nbrs, ct, mt);
    end
    @(negedge clk);
    pixel_valid_i = 1'b0;
    repeat (3) @(negedge clk);
    read_histogram("random", 1);
    check_bins("random");
    // pixels seen during the last readout must not show up here
    read_histogram("repeat", 0);
    check_bins("repeat");

    read_histogram("abort", 2);
    for (int b = 0; b < NUM_BINS; b++) begin
      exp_count[b] = 0;
    end
    read_histogram("after clear", 0);
    check_bins("after clear");

    $display("errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
    if (mismatch_errors == 0 && other_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/clbp_vectors.hex
// first word: number of windows
// then per line: centre n0 n1 n2 n3 n4 n5 n6 n7 c_thresh m_thresh expected_bin
1e
80 80 80 80 80 80 80 80 80 80 10 b4
80 7f 7f 7f 7f 7f 7f 7f 7f 80 10 64
80 7f 7f 7f 7f 7f 7f 7f 7f 81 10 00
80 90 90 90 90 90 90 90 90 80 10 bc
80 70 70 70 70 70 70 70 70 80 10 6c
80 90 90 90 90 70 70 70 70 80 10 94
80 90 7f 7f 7f 7f 7f 7f 7f 80 10 6f
80 90 70 90 70 90 70 90 70 80 10 c6
80 80 7f 80 7f 80 7f 80 7f 80 10 be
80 90 80 90 80 90 80 90 80 80 10 bd
80 80 80 80 80 80 80 80 80 ff 10 50
80 70 7f 70 7f 70 7f 70 7f ff 10 09
80 90 70 90 70 90 70 90 70 ff 10 62
80 90 7f 90 7f 90 7f 90 7f ff 10 63
80 a0 a0 a0 60 60 60 60 60 00 20 8a
80 a0 a0 a0 60 60 60 60 60 00 21 82
80 90 90 90 90 90 90 70 70 80 20 a0
80 a0 90 a0 90 7f 7f 7f 7f 80 20 95
80 90 90 7f 7f 90 90 7f 7f 80 10 c7
80 60 60 60 60 60 60 60 a0 80 20 76
00 00 00 00 00 00 00 00 00 00 01 b4
00 00 00 00 00 00 00 00 00 01 00 58
ff ff ff ff ff ff ff ff ff 80 00 bc
ff 00 00 00 00 00 00 00 00 80 ff 6c
10 20 20 00 00 00 00 00 00 80 10 1c
10 20 20 00 00 00 00 00 00 80 11 14
80 7f 7f 7f 7f 7f 7f 7f 7f 80 01 6c
80 80 80 80 80 80 80 80 80 80 10 b4
80 90 90 7f 7f 90 90 7f 7f 80 10 c7
80 90 70 70 70 70 70 70 90 80 10 80

// File: build.f
hw/clbp_pkg.sv
hw/jh_ctrl_pkg.sv
hw/clbp_code_if.sv
hw/clbp_encoder.sv
hw/joint_hist_datapath.sv
hw/jh_controller.sv
hw/clbp_hist_top.sv
tests/clbp_hist_assertions.sv
tests/tb_clbp_hist.sv

// File: Makefile
SIM = obj_dir/Vtb_clbp_hist

.PHONY: all run clean

all: run

$(SIM): build.f $(wildcard hw/*.sv tests/*.sv)
	verilator --binary --assert -Wno-fatal -j 0 --top-module tb_clbp_hist -Mdir obj_dir -f build.f

run: $(SIM) tests/clbp_vectors.hex
	./$(SIM) | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
